// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lbus_rx_aligner
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard hw/*.sv tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+tests
hw/lbus_pkg.sv
hw/lbus_rx_fifo.sv
hw/lbus_beat_window.sv
hw/lbus_realign_fsm.sv
hw/lbus_rx_aligner.sv
tests/tb_lbus_rx_aligner.sv

// ==== hw/lbus_beat_window.sv ====
// window_depth must be a power of two >= 4; holds at most window_depth-1 beats so prev_beat is kept
`timescale 1ns/1ns

module lbus_beat_window import lbus_pkg::*; #(
  parameter int window_depth = 8
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  logic       fifo_empty,
  output logic       fifo_rd,
  input  lbus_beat_t fifo_beat,
  input  logic       advance,
  output logic       beat_avail,
  output lbus_beat_t prev_beat,
  output lbus_beat_t curr_beat
);

  localparam int aw = $clog2(window_depth);
  localparam logic [aw:0] rd_limit = (aw+1)'(window_depth - 2);

  lbus_beat_t store [window_depth];

  logic [aw:0]   wr_ptr;
  logic [aw:0]   rd_ptr;
  logic [aw:0]   occupancy;
  logic [aw-1:0] prev_idx;
  logic          rd_d1;  // fifo read in flight, data on fifo_beat now

  assign occupancy  = wr_ptr - rd_ptr;
  assign beat_avail = (occupancy != '0);

  // prefetch while there is headroom, counting the beat still in flight
  assign fifo_rd = !fifo_empty && ((occupancy + {{aw{1'b0}}, rd_d1}) <= rd_limit);

  assign prev_idx  = rd_ptr[aw-1:0] - 1'b1;
  assign prev_beat = store[prev_idx];  // last popped beat
  assign curr_beat = store[rd_ptr[aw-1:0]];

  always_ff @(posedge CLK) begin
    if (user_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      rd_d1  <= 1'b0;
    end else begin
      rd_d1 <= fifo_rd;
      if (rd_d1) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (advance) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_d1) begin
      store[wr_ptr[aw-1:0]] <= fifo_beat;
    end
  end

  // realign FSM may only pop a beat it has seen
  a_pop_when_avail: assert property (@(posedge CLK) disable iff (user_rst)
    advance |-> beat_avail)
    else $error("lbus_beat_window: advance on empty window");

endmodule

// ==== hw/lbus_pkg.sv ====
// shared LBUS types; segment widths are fixed for the 4x128 bit 100G bus and not meant to change
package lbus_pkg;

  localparam int seg_count  = 4;
  localparam int seg_data_w = 128;
  localparam int mty_w      = 4;

  typedef logic [1:0] lane_t;

  // one 128 bit segment with its sideband
  typedef struct packed {
    logic             en;
    logic             sop;
    logic             eop;
    logic             err;
    logic [mty_w-1:0] mty;
    logic [seg_data_w-1:0] data;
  } lbus_seg_t;

  // lane 0 is the earliest segment in time
  typedef lbus_seg_t [seg_count-1:0] lbus_beat_t;

  typedef enum logic [2:0] {
    idle,
    in_burst,
    first_part,    // head of a packet waits in prev_beat
    end_no_burst,
    end_in_burst   // tail emitted, next packet already started in same beat
  } realign_state_t;

endpackage

// ==== hw/lbus_realign_fsm.sv ====
// mid-packet beats are assumed full; at most one sop and one eop per beat, a packet never spans a gap
`timescale 1ns/1ns

module lbus_realign_fsm import lbus_pkg::*; (
  input  logic       CLK,
  input  logic       user_rst,
  input  logic       beat_avail,
  input  lbus_beat_t prev_beat,
  input  lbus_beat_t curr_beat,
  output logic       advance,
  output lbus_beat_t rx_out
);

  realign_state_t state;
  realign_state_t state_next;
  lane_t          offset;       // lane where the open packet's sop arrived
  lane_t          offset_next;
  lane_t          shift_lane;
  lane_t          sop_lane;
  lane_t          eop_lane;
  logic           curr_has_sop;
  logic           curr_has_eop;
  logic           single_beat;
  logic           next_sop;
  logic           eop_fits;
  logic           emit;
  lbus_beat_t     lo_beat;
  lbus_beat_t     out_next;

  logic [seg_count-1:0] out_en;
  logic [seg_count-1:0] out_sop;
  logic [seg_count-1:0] out_eop;
  logic                 out_closed;

  // lanes off..3 of lo followed by lanes 0..off-1 of hi
  function automatic lbus_beat_t shift_beat(lbus_beat_t lo, lbus_beat_t hi, lane_t off);
    lbus_beat_t res;
    for (int i = 0; i < seg_count; i++) begin
      if (i + off < seg_count) begin
        res[i] = lo[i + off];
      end else begin
        res[i] = hi[i + off - seg_count];
      end
    end
    return res;
  endfunction

  // keep contiguous enabled lanes up to and including the first eop
  function automatic lbus_beat_t trim_beat(lbus_beat_t b);
    lbus_beat_t res;
    logic       open;
    res  = '0;
    open = 1'b1;
    for (int i = 0; i < seg_count; i++) begin
      if (!b[i].en) begin
        open = 1'b0;
      end
      if (open) begin
        res[i] = b[i];
      end
      if (b[i].eop) begin
        open = 1'b0;
      end
    end
    return res;
  endfunction

  always_comb begin
    curr_has_sop = 1'b0;
    curr_has_eop = 1'b0;
    sop_lane     = '0;
    eop_lane     = '0;
    for (int i = 0; i < seg_count; i++) begin
      if (curr_beat[i].en && curr_beat[i].sop) begin
        curr_has_sop = 1'b1;
        sop_lane     = lane_t'(i);
      end
      if (curr_beat[i].en && curr_beat[i].eop) begin
        curr_has_eop = 1'b1;
        eop_lane     = lane_t'(i);
      end
    end
  end

  assign single_beat = curr_has_eop && (eop_lane >= sop_lane);
  assign next_sop    = curr_has_sop && curr_has_eop && (sop_lane > eop_lane);
  assign eop_fits    = (offset == '0) || (eop_lane < offset);  // tail fits the shifted beat

  always_comb begin
    state_next  = state;
    offset_next = offset;
    advance     = 1'b0;
    emit        = 1'b0;
    lo_beat     = curr_beat;
    shift_lane  = offset;
    case (state)
      idle: begin
        shift_lane = sop_lane;
        if (beat_avail) begin
          advance = 1'b1;  // stray segments without sop are dropped
          if (curr_has_sop) begin
            if (single_beat) begin
              emit = 1'b1;
            end else if (sop_lane == '0) begin
              emit        = 1'b1;
              offset_next = '0;
              state_next  = in_burst;
            end else begin
              offset_next = sop_lane;  // wait for the next beat to fill the output
              state_next  = first_part;
            end
          end
        end
      end
      first_part, in_burst: begin
        if (offset != '0) begin
          lo_beat = prev_beat;
        end
        if (beat_avail) begin
          emit = 1'b1;
          if (!curr_has_eop) begin
            advance    = 1'b1;
            state_next = in_burst;
          end else if (eop_fits) begin
            advance     = 1'b1;
            offset_next = next_sop ? sop_lane : '0;
            state_next  = next_sop ? first_part : idle;
          end else begin
            // tail sits past the offset, emit it next cycle from curr_beat
            state_next = next_sop ? end_in_burst : end_no_burst;
          end
        end
      end
      end_no_burst, end_in_burst: begin
        emit        = 1'b1;
        advance     = 1'b1;
        offset_next = (state == end_in_burst) ? sop_lane : '0;
        state_next  = (state == end_in_burst) ? first_part : idle;
      end
      default: state_next = idle;
    endcase
  end

  assign out_next = emit ? trim_beat(shift_beat(lo_beat, curr_beat, shift_lane)) : '0;

  always_ff @(posedge CLK) begin
    if (user_rst) begin
      state  <= idle;
      offset <= '0;
    end else begin
      state  <= state_next;
      offset <= offset_next;
    end
  end

  always_ff @(posedge CLK) begin
    rx_out <= out_next;
    if (user_rst) begin
      for (int i = 0; i < seg_count; i++) begin
        rx_out[i].en <= 1'b0;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < seg_count; i++) begin
      out_en[i]  = rx_out[i].en;
      out_sop[i] = rx_out[i].sop;
      out_eop[i] = rx_out[i].eop;
    end
  end

  // set once the last non-idle output beat carried an eop
  always_ff @(posedge CLK) begin
    if (user_rst) begin
      out_closed <= 1'b1;
    end else if (|out_en) begin
      out_closed <= |out_eop;
    end
  end

  a_head_in_lane0: assert property (@(posedge CLK) disable iff (user_rst)
    ((|out_en) && out_closed) |-> (rx_out[0].en && rx_out[0].sop))
    else $error("lbus_realign_fsm: packet head not in lane 0");

  a_sop_only_lane0: assert property (@(posedge CLK) disable iff (user_rst)
    !(|out_sop[seg_count-1:1]))
    else $error("lbus_realign_fsm: sop outside lane 0");

endmodule

// ==== hw/lbus_rx_aligner.sv ====
// no back-pressure; the MAC must leave an idle beat after any beat where one packet ends and another starts
`timescale 1ns/1ns

module lbus_rx_aligner import lbus_pkg::*; #(
  parameter int fifo_depth   = 16,
  parameter int window_depth = 8
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  lbus_beat_t rx_in,
  output lbus_beat_t rx_out
);

  lbus_beat_t cap_beat;
  logic       cap_valid;  // captured beat has at least one segment
  lbus_beat_t fifo_beat;
  logic       fifo_rd;
  logic       fifo_empty;
  logic       beat_avail;
  logic       advance;
  lbus_beat_t prev_beat;
  lbus_beat_t curr_beat;

  logic [seg_count-1:0] in_en;

  always_comb begin
    for (int i = 0; i < seg_count; i++) begin
      in_en[i] = rx_in[i].en;
    end
  end

  // input capture
  always_ff @(posedge CLK) begin
    cap_beat <= rx_in;
    if (user_rst) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= |in_en;  // idle beats never enter the FIFO
    end
  end

  lbus_rx_fifo #(
    .fifo_depth(fifo_depth)
  ) lbus_rx_fifo_i (
    .CLK     (CLK),
    .user_rst(user_rst),
    .wr_en   (cap_valid),
    .wr_beat (cap_beat),
    .rd_en   (fifo_rd),
    .rd_beat (fifo_beat),
    .empty   (fifo_empty)
  );

  lbus_beat_window #(
    .window_depth(window_depth)
  ) lbus_beat_window_i (
    .CLK       (CLK),
    .user_rst  (user_rst),
    .fifo_empty(fifo_empty),
    .fifo_rd   (fifo_rd),
    .fifo_beat (fifo_beat),
    .advance   (advance),
    .beat_avail(beat_avail),
    .prev_beat (prev_beat),
    .curr_beat (curr_beat)
  );

  lbus_realign_fsm lbus_realign_fsm_i (
    .CLK       (CLK),
    .user_rst  (user_rst),
    .beat_avail(beat_avail),
    .prev_beat (prev_beat),
    .curr_beat (curr_beat),
    .advance   (advance),
    .rx_out    (rx_out)
  );

endmodule

// ==== hw/lbus_rx_fifo.sv ====
// fifo_depth must be a power of two; read data appears one clock after rd_en, no full flag out
`timescale 1ns/1ns

module lbus_rx_fifo import lbus_pkg::*; #(
  parameter int fifo_depth = 16
) (
  input  logic       CLK,
  input  logic       user_rst,
  input  logic       wr_en,
  input  lbus_beat_t wr_beat,
  input  logic       rd_en,
  output lbus_beat_t rd_beat,
  output logic       empty
);

  localparam int aw = $clog2(fifo_depth);

  lbus_beat_t mem [fifo_depth];

  logic [aw:0] wr_ptr;  // msb is the wrap bit
  logic [aw:0] rd_ptr;
  logic        full;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

  always_ff @(posedge CLK) begin
    if (user_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage and registered read port
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr[aw-1:0]] <= wr_beat;
    end
    if (rd_en) begin
      rd_beat <= mem[rd_ptr[aw-1:0]];
    end
  end

  // the MAC has no back-pressure, so a full FIFO means the idle-beat rule was broken upstream
  a_no_overflow: assert property (@(posedge CLK) disable iff (user_rst) !(wr_en && full))
    else $error("lbus_rx_fifo: write while full");

  // window must only pull what is there
  a_no_underflow: assert property (@(posedge CLK) disable iff (user_rst) !(rd_en && empty))
    else $error("lbus_rx_fifo: read while empty");

endmodule

// ==== tests/lbus_checks.svh ====
// included inside tb_lbus_rx_aligner after its seed, queues and counters are declared

  // value in 0..n-1 from the seeded generator
  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // reference model; one packet's segments in time order, mty and err only on the eop segment
  task automatic model_packet(int len, int mty, int err);
    lbus_seg_t s;
    pkt_q.delete();
    for (int k = 0; k < len; k++) begin
      s      = '0;
      s.en   = 1'b1;
      s.sop  = (k == 0);
      s.eop  = (k == len - 1);
      s.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      if (k == len - 1) begin
        s.mty = mty_w'(mty);
        s.err = (err != 0);
      end
      pkt_q.push_back(s);
      exp_q.push_back(s);  // rx_out must show the same stream
    end
    exp_pkts++;
  endtask

  task automatic check_seg(lbus_seg_t exp, lbus_seg_t got, string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic check_count(int exp, int got, string name);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
    end
  endtask

// ==== tests/tb_lbus_rx_aligner.sv ====
// packet table plus 40 seeded random rows; a gap of 0 shares the eop beat only where the bus rules allow
`timescale 1ns/1ns

module tb_lbus_rx_aligner import lbus_pkg::*; ();

  typedef struct packed {
    int len;    // segments
    int start;  // sop lane when the packet opens a fresh beat
    int mty;
    int err;
    int gap;    // idle beats after; 0 lets the next sop share the eop beat
  } row_t;

  localparam int fixed_rows  = 22;
  localparam int random_rows = 40;
  localparam int total_rows  = fixed_rows + random_rows;
  localparam int pkt_timeout = 200;

  logic       CLK;
  logic       user_rst;
  lbus_beat_t rx_in;
  lbus_beat_t rx_out;

  row_t      rows [total_rows];
  lbus_seg_t exp_q [$];
  lbus_seg_t pkt_q [$];
  integer    seed = 89740;
  int        errors;
  int        checks;
  int        exp_pkts;
  int        rx_pkts;
  bit        timed_out;

  `include "lbus_checks.svh"

  lbus_rx_aligner #(
    .fifo_depth  (16),
    .window_depth(8)
  ) lbus_rx_aligner_i (
    .CLK     (CLK),
    .user_rst(user_rst),
    .rx_in   (rx_in),
    .rx_out  (rx_out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic fill_table();
    //          len start mty err gap
    rows[0]  = '{1, 0, 0,  0, 1};  // lane 0 with lengths 1 to 9
    rows[1]  = '{2, 0, 5,  0, 1};
    rows[2]  = '{3, 0, 15, 0, 2};
    rows[3]  = '{4, 0, 0,  1, 1};
    rows[4]  = '{5, 0, 8,  0, 1};
    rows[5]  = '{6, 0, 1,  0, 3};
    rows[6]  = '{7, 0, 12, 1, 1};
    rows[7]  = '{8, 0, 3,  0, 1};
    rows[8]  = '{9, 0, 14, 0, 2};
    rows[9]  = '{3, 1, 2,  0, 1};  // offset starts
    rows[10] = '{6, 2, 5,  0, 1};
    rows[11] = '{2, 3, 0,  1, 2};
    rows[12] = '{5, 3, 11, 0, 1};
    rows[13] = '{1, 2, 6,  0, 1};
    rows[14] = '{8, 1, 0,  1, 1};
    rows[15] = '{4, 3, 13, 0, 2};
    rows[16] = '{6, 0, 3,  0, 0};  // shared eop/sop beats
    rows[17] = '{5, 2, 7,  1, 1};
    rows[18] = '{6, 1, 0,  0, 0};
    rows[19] = '{3, 3, 9,  0, 1};
    rows[20] = '{3, 3, 1,  0, 0};
    rows[21] = '{4, 2, 15, 1, 2};
    for (int r = fixed_rows; r < total_rows; r++) begin
      rows[r].len   = 1 + rand_below(9);
      rows[r].start = rand_below(seg_count);
      rows[r].mty   = rand_below(16);
      rows[r].err   = rand_below(2);
      rows[r].gap   = rand_below(4);
    end
  endtask

  task automatic drive_beat(lbus_beat_t b);
    @(posedge CLK);
    #1;
    rx_in = b;
  endtask

  // pack table rows into beats; an idle beat always follows a shared beat's second packet
  task automatic send_rows(int first, int last);
    lbus_beat_t cur;
    int         lane;
    int         idles;
    bit         shared_into;
    bit         share_next;
    bit         fresh;  // packet still in its first beat
    cur         = '0;
    lane        = 0;
    shared_into = 1'b0;
    for (int r = first; r <= last; r++) begin
      model_packet(rows[r].len, rows[r].mty, rows[r].err);
      if (!shared_into) begin
        cur  = '0;
        lane = rows[r].start;
      end
      fresh = 1'b1;
      foreach (pkt_q[k]) begin
        cur[lane] = pkt_q[k];
        lane++;
        if (lane == seg_count) begin
          drive_beat(cur);
          cur   = '0;
          lane  = 0;
          fresh = 1'b0;
        end
      end
      share_next = (rows[r].gap == 0) && !shared_into && !fresh && (lane != 0) &&
                   (r < last) && (lane + rows[r + 1].len > seg_count);
      if (!share_next) begin
        if (lane != 0) begin
          drive_beat(cur);
        end
        idles = (rows[r].gap == 0) ? 1 : rows[r].gap;
        repeat (idles) drive_beat('0);
      end
      shared_into = share_next;
    end
  endtask

  task automatic wait_packets();
    int last_count;
    int stall;
    last_count = rx_pkts;
    stall      = 0;
    while (rx_pkts < exp_pkts && !timed_out) begin
      @(posedge CLK);
      if (rx_pkts != last_count) begin
        last_count = rx_pkts;
        stall      = 0;
      end else begin
        stall++;
      end
      if (stall >= pkt_timeout) begin
        $display("packet %0d never arrived on rx_out within %0d cycles", rx_pkts + 1, pkt_timeout);
        errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic run_test(int num, string name, int first, int last);
    int err_before;
    err_before = errors;
    if (!timed_out) begin
      send_rows(first, last);
      drive_beat('0);
      wait_packets();
      check_count(exp_pkts, rx_pkts, "packet count");
      $display("test %0d %s: %0d packets received, %s", num, name, rx_pkts,
               (errors == err_before) ? "ok" : "errors");
    end
  endtask

  // rebuild packets from rx_out one beat at a time
  task automatic collect_beat(lbus_beat_t b);
    lbus_seg_t exp;
    bit        closed;  // gap or eop seen earlier in this beat
    bit        after_eop;
    closed    = 1'b0;
    after_eop = 1'b0;
    for (int i = 0; i < seg_count; i++) begin
      if ($isunknown(b[i].en)) begin
        $display("FAILED t=%0t rx_out[%0d].en exp=0 got=%b", $time, i, b[i].en);
        errors++;
      end
      if (b[i].en !== 1'b1) begin
        if (after_eop) begin
          check_seg('0, b[i], $sformatf("rx_out[%0d]", i));  // lanes past eop are cleared
        end
        closed = 1'b1;
      end else begin
        if (closed) begin
          $display("rx_out lane %0d holds a segment after a gap or an eop at t=%0t", i, $time);
          errors++;
        end
        if (b[i].sop && i != 0) begin
          $display("rx_out sop arrived in lane %0d instead of lane 0 at t=%0t", i, $time);
          errors++;
        end
        if (exp_q.size() == 0) begin
          $display("rx_out lane %0d holds a segment with no packet expected at t=%0t", i, $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check_seg(exp, b[i], $sformatf("rx_out[%0d]", i));
        end
        if (b[i].eop) begin
          closed    = 1'b1;
          after_eop = 1'b1;
          rx_pkts++;
        end
      end
    end
  endtask

  // falling edge samples, starting once the first rising edge has reset rx_out
  initial begin
    @(posedge CLK);
    forever begin
      @(negedge CLK);
      collect_beat(rx_out);
    end
  end

  task automatic finish_run();
    $display("checks %0d, errors %0d, packets %0d of %0d", checks, errors, rx_pkts, exp_pkts);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin
    user_rst  = 1'b1;
    rx_in     = '0;
    errors    = 0;
    checks    = 0;
    exp_pkts  = 0;
    rx_pkts   = 0;
    timed_out = 1'b0;
    fill_table();
    repeat (2) @(posedge CLK);
    #1;
    user_rst = 1'b0;
    repeat (10) drive_beat('0);  // rx_out must stay idle
    $display("test 1 idle after reset: %s", (errors == 0) ? "ok" : "errors");
    run_test(2, "lane 0 lengths", 0, 8);
    run_test(3, "offset lanes", 9, 15);
    run_test(4, "shared beats", 16, fixed_rows - 1);
    run_test(5, "random mix", fixed_rows, total_rows - 1);
    finish_run();
  end

endmodule
